// File: dv/tb_umi_mem_agent.sv
`timescale 1ns/1ps
`include "mem_agent_defs.svh"

module tb_umi_mem_agent
   import mem_agent_pkg::*;
   ();

   localparam int NROWS = `MA_RAMDEPTH;
   localparam int NREQ  = NROWS + 32 + 128 + 32 + 64 + 200;   // Requests over all tests

   typedef struct packed {
      cmd_t  cmd;
      addr_t dst;
      addr_t src;
      data_t data;
   } resp_t;

   logic  clk;
   logic  nreset;
   logic  req_valid;
   cmd_t  req_cmd;
   addr_t req_dstaddr;
   addr_t req_srcaddr;
   data_t req_data;
   logic  req_ready;
   logic  resp_valid;
   cmd_t  resp_cmd;
   addr_t resp_dstaddr;
   addr_t resp_srcaddr;
   data_t resp_data;
   logic  resp_ready;

   logic [7:0] ref_mem [NROWS*8];                      // Byte model of the 2 KB RAM
   resp_t      exp_q [$];                              // Expected responses in order
   resp_t      held;                                   // Packet seen while stalled
   logic       stalled    = 1'b0;
   logic       bp_on      = 1'b0;                      // Random resp_ready drops
   logic       park_ready = 1'b1;                      // resp_ready low until the reset check
   string      cur_test;
   int         errors    = 0;
   int         test_errs = 0;
   int         n_tests   = 0;
   int         n_failed  = 0;
   int         n_checked = 0;

   umi_mem_agent dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                           // 8 ns period
   end

   initial begin
      forever begin
         @(negedge clk);
         if (park_ready)
            resp_ready = 1'b0;                         // Only an empty register frees req_ready
         else
            resp_ready = bp_on ? (($urandom % 3) != 0) : 1'b1;   // Roughly one stall in three
      end
   end

   initial begin
      repeat (NREQ * 20 + 1000) @(posedge clk);
      $display("Watchdog expired, the agent stopped answering in test %s", cur_test);
      $display(">>> FAIL");
      $finish;
   end

   // ##########################################################################
   // Reference model and comparator
   // ##########################################################################

   // Apply one accepted request and queue its response
   function automatic void apply_request(cmd_t cmd, addr_t dst, addr_t src, data_t data);
      resp_t r;
      int    off;
      int    cnt;
      int    base;
      off  = dst[2:0];                                 // Byte offset in the row
      cnt  = (int'(cmd[15:8]) + 1) << cmd[7:5];        // Elements times element bytes
      base = int'(dst[10:3]) * 8;
      r.cmd  = {16'h0000, cmd[15:8], cmd[7:5], (cmd[4:0] == REQ_RD) ? RESP_RD : RESP_WR};
      r.dst  = src;                                    // Addresses swap
      r.src  = dst;
      r.data = '0;
      if (cmd[4:0] == REQ_RD) begin
         for (int b = off; b < 8; b++)
            r.data[(b-off)*8 +: 8] = ref_mem[base+b];  // Shift down with zero fill
      end else begin
         for (int b = off; b < off + cnt && b < 8; b++)
            ref_mem[base+b] = data[(b-off)*8 +: 8];
      end
      if (cmd[4:0] != REQ_WRPOSTED)
         exp_q.push_back(r);
   endfunction

   task automatic mismatch(string field, logic [63:0] want, logic [63:0] got);
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, field, want, got);
      errors++;
   endtask

   task automatic report_fault(string msg);
      $display("[ERROR] %s: %s", cur_test, msg);
      errors++;
   endtask

   always @(posedge clk) begin
      if (nreset && req_valid && req_ready)
         apply_request(req_cmd, req_dstaddr, req_srcaddr, req_data);
   end

   always @(posedge clk) begin : compare
      resp_t want;
      if (nreset && resp_valid) begin
         if (stalled && held !== {resp_cmd, resp_dstaddr, resp_srcaddr, resp_data})
            report_fault("response packet changed while it was stalled");
         stalled = !resp_ready;
         held    = {resp_cmd, resp_dstaddr, resp_srcaddr, resp_data};
         if (resp_ready && exp_q.size() == 0) begin
            report_fault("a response came back that no request asked for");
         end else if (resp_ready) begin
            want = exp_q.pop_front();
            n_checked++;
            if (resp_cmd !== want.cmd)
               mismatch("cmd", want.cmd, resp_cmd);
            if (resp_dstaddr !== want.dst)
               mismatch("dstaddr", want.dst, resp_dstaddr);
            if (resp_srcaddr !== want.src)
               mismatch("srcaddr", want.src, resp_srcaddr);
            if (resp_data !== want.data)
               mismatch("data", want.data, resp_data);
         end
      end else if (stalled) begin
         report_fault("resp_valid dropped before the response transferred");
         stalled = 1'b0;
      end
   end

   // ##########################################################################
   // Drivers
   // ##########################################################################

   task automatic send_req(opcode_t op, size_t size, len_t len, row_t row, logic [2:0] off);
      addr_t dst;
      dst = $urandom;                                  // Upper bits ignored by the RAM
      dst[10:0] = {row, off};
      @(negedge clk);
      req_valid   = 1'b1;
      req_cmd     = {16'h0000, len, size, op};
      req_dstaddr = dst;
      req_srcaddr = $urandom;
      req_data    = {$urandom, $urandom};
      do @(posedge clk); while (!req_ready);           // Held until accepted
   endtask

   // Random offset, size and len inside one word
   task automatic send_legal(opcode_t op, row_t row);
      logic [2:0] off;
      size_t      size;
      int         room;
      do begin
         off  = $urandom % 8;
         size = $urandom % 4;
         room = (8 - off) >> size;                     // Elements that still fit
      end while (room == 0);
      send_req(op, size, len_t'($urandom % room), row, off);
   endtask

   task automatic finish_test();
      @(negedge clk);
      req_valid = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);                       // Room for stray responses
      n_tests++;
      if (errors != test_errs)
         n_failed++;
      $display("Test %-12s done, %0d errors", cur_test, errors - test_errs);
      test_errs = errors;
   endtask

   initial begin : main
      row_t    row;
      opcode_t op;
      void'($urandom(32'hddbd_c542));
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      resp_ready  = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;

      cur_test = "reset";
      @(negedge clk);
      if (resp_valid !== 1'b0)
         mismatch("resp_valid", 0, resp_valid);
      if (req_ready !== 1'b1)
         mismatch("req_ready", 1, req_ready);
      park_ready = 1'b0;
      finish_test();

      cur_test = "full_word";                          // Every row gets known data
      for (int r = 0; r < NROWS; r++)
         send_req(REQ_WR, 3'd3, 8'd0, row_t'(r), 3'd0);
      for (int i = 0; i < 32; i++)
         send_req(REQ_RD, 3'd3, 8'd0, row_t'($urandom), 3'd0);
      finish_test();

      cur_test = "partial";                            // Few rows for heavy overlap
      for (int i = 0; i < 64; i++)
         send_legal(REQ_WR, row_t'($urandom % 16));
      for (int i = 0; i < 64; i++)
         send_legal(REQ_RD, row_t'($urandom % 16));
      finish_test();

      cur_test = "posted";
      for (int i = 0; i < 16; i++) begin
         row = $urandom;
         send_legal(REQ_WRPOSTED, row);
         send_req(REQ_RD, 3'd3, 8'd0, row, 3'd0);      // Shows the data landed
      end
      finish_test();

      cur_test = "back_to_back";
      for (int i = 0; i < 32; i++) begin
         row = $urandom;
         send_legal(REQ_WR, row);
         send_req(REQ_RD, 3'd3, 8'd0, row, 3'd0);      // Next cycle to the same row
      end
      finish_test();

      cur_test = "backpressure";
      bp_on = 1'b1;
      for (int i = 0; i < 200; i++) begin
         case ($urandom % 3)
            0:       op = REQ_RD;
            1:       op = REQ_WR;
            default: op = REQ_WRPOSTED;
         endcase
         send_legal(op, row_t'($urandom % 32));
      end
      finish_test();
      bp_on = 1'b0;

      $display("Summary: %0d tests, %0d failed, %0d responses checked, %0d errors",
               n_tests, n_failed, n_checked, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: files.f
+incdir+hdl
hdl/mem_agent_pkg.sv
hdl/mem_agent_if.sv
hdl/umi_req_decode.sv
hdl/mem_access_exec.sv
hdl/umi_resp_builder.sv
hdl/umi_mem_agent.sv
dv/tb_umi_mem_agent.sv

// File: hdl/mem_access_exec.sv
`timescale 1ns/1ps
`include "mem_agent_defs.svh"

module mem_access_exec
   import mem_agent_pkg::*;
   (
   input  logic clk,
   input  logic nreset,
   input  logic advance,
   dec_exe_if.dst dec,
   exe_res_if.src exe
   );

   localparam int NBYTES = $bits(bmask_t);             // Bytes per row
   localparam int OFFW   = $clog2(NBYTES);             // Byte offset bits

   logic [OFFW-1:0] wr_off;
   logic [15:0]     byte_cnt;                          // Wide enough for len 255, size 7
   logic [15:0]     byte_end;
   bmask_t          bmask;
   data_t           wr_aligned;
   row_t            row;
   logic            wr_en;

   data_t           mem [`MA_RAMDEPTH];                // Local RAM array
   data_t           rd_row;                            // Sync RAM output

   logic    exe_valid;
   opcode_t exe_opcode;
   size_t   exe_size;
   len_t    exe_len;
   addr_t   exe_dstaddr;
   addr_t   exe_srcaddr;

   // ##########################################################################
   // Byte mask and write alignment
   // ##########################################################################

   assign wr_off   = dec.dstaddr[OFFW-1:0];
   assign row      = dec.dstaddr[OFFW +: $bits(row_t)];     // Bits 10..3
   assign byte_cnt = ({8'h00, dec.len} + 16'd1) << dec.size;
   assign byte_end = {{(16-OFFW){1'b0}}, wr_off} + byte_cnt;

   // Enable bytes in [offset, offset+count)
   always_comb begin
      for (int i = 0; i < NBYTES; i++)
         bmask[i] = (i >= int'(wr_off)) && (i < int'(byte_end));
   end

   assign wr_aligned = dec.wrdata << {wr_off, 3'b000};     // Byte lanes up to offset

   // Posted and acked writes both land here
   assign wr_en = advance && dec.valid &&
                  ((dec.opcode == REQ_WR) || (dec.opcode == REQ_WRPOSTED));

   // ##########################################################################
   // RAM array
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < NBYTES; i++)
            if (bmask[i])
               mem[row][i*8 +: 8] <= wr_aligned[i*8 +: 8];
      end
      if (advance)
         rd_row <= mem[row];                           // Held under back-pressure
   end

   // Execute slot
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         exe_valid <= 1'b0;
      else if (advance)
         exe_valid <= dec.valid;
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         exe_opcode  <= dec.opcode;
         exe_size    <= dec.size;
         exe_len     <= dec.len;
         exe_dstaddr <= dec.dstaddr;                   // Offset rides along with it
         exe_srcaddr <= dec.srcaddr;
      end
   end

   assign exe.valid   = exe_valid;
   assign exe.opcode  = exe_opcode;
   assign exe.size    = exe_size;
   assign exe.len     = exe_len;
   assign exe.dstaddr = exe_dstaddr;
   assign exe.srcaddr = exe_srcaddr;
   assign exe.rddata  = rd_row >> {exe_dstaddr[OFFW-1:0], 3'b000};   // Zero fill on top

endmodule

// File: hdl/mem_agent_defs.svh
`ifndef MEM_AGENT_DEFS_SVH
`define MEM_AGENT_DEFS_SVH

// ##########################################################################
// Memory agent widths and sizes
// ##########################################################################

// Packet data word, one RAM row
`define MA_DW 64

// Destination and source address
`define MA_AW 32

// Command word, opcode/size/len packed in the low bits
`define MA_CW 32

// Rows of MA_DW bits, 256 x 8 bytes = 2 KB
`define MA_RAMDEPTH 256

`endif

// File: hdl/mem_agent_if.sv
`timescale 1ns/1ps

// Decode slot to execute stage
interface dec_exe_if
   import mem_agent_pkg::*;
   ();

   logic    valid;                                     // Slot holds a legal request
   opcode_t opcode;
   size_t   size;
   len_t    len;
   addr_t   dstaddr;                                   // Target byte address
   addr_t   srcaddr;                                   // Return address
   data_t   wrdata;                                    // Unaligned write data

   modport src (output valid, output opcode, output size, output len,
                output dstaddr, output srcaddr, output wrdata);

   modport dst (input valid, input opcode, input size, input len,
                input dstaddr, input srcaddr, input wrdata);

endinterface

// Execute slot to response builder
interface exe_res_if
   import mem_agent_pkg::*;
   ();

   logic    valid;
   opcode_t opcode;                                    // Still the request opcode
   size_t   size;
   len_t    len;
   addr_t   dstaddr;
   addr_t   srcaddr;
   data_t   rddata;                                    // Row already shifted down

   modport src (output valid, output opcode, output size, output len,
                output dstaddr, output srcaddr, output rddata);

   modport dst (input valid, input opcode, input size, input len,
                input dstaddr, input srcaddr, input rddata);

endinterface

// File: hdl/mem_agent_pkg.sv
`include "mem_agent_defs.svh"

package mem_agent_pkg;

   // ##########################################################################
   // Vector types
   // ##########################################################################

   typedef logic [`MA_DW-1:0] data_t;                  // One packet data word
   typedef logic [`MA_AW-1:0] addr_t;                  // Byte address
   typedef logic [`MA_CW-1:0] cmd_t;                   // Full command word
   typedef logic [4:0]        opcode_t;                // Command opcode field
   typedef logic [2:0]        size_t;                  // log2 of element bytes
   typedef logic [7:0]        len_t;                   // Element count minus one
   typedef logic [7:0]        bmask_t;                 // One enable per data byte
   typedef logic [$clog2(`MA_RAMDEPTH)-1:0] row_t;     // RAM row index

   // ##########################################################################
   // Command word layout
   // ##########################################################################

   // Fields are LSB-anchored, upper bits zero
   localparam int CMD_OPCODE_LSB = 0;                  // Bits 4..0
   localparam int CMD_SIZE_LSB   = 5;                  // Bits 7..5
   localparam int CMD_LEN_LSB    = 8;                  // Bits 15..8

   // Request opcodes
   localparam opcode_t REQ_RD       = 5'd1;
   localparam opcode_t REQ_WR       = 5'd3;
   localparam opcode_t REQ_WRPOSTED = 5'd5;            // Write, no ack

   // Response opcodes
   localparam opcode_t RESP_RD = 5'd2;                 // Carries read data
   localparam opcode_t RESP_WR = 5'd4;                 // Write ack, zero data

endpackage

// File: hdl/umi_mem_agent.sv
`timescale 1ns/1ps

module umi_mem_agent
   import mem_agent_pkg::*;
   (
   input  logic  clk,
   input  logic  nreset,
   // Request channel
   input  logic  req_valid,
   input  cmd_t  req_cmd,
   input  addr_t req_dstaddr,
   input  addr_t req_srcaddr,
   input  data_t req_data,
   output logic  req_ready,
   // Response channel
   output logic  resp_valid,
   output cmd_t  resp_cmd,
   output addr_t resp_dstaddr,
   output addr_t resp_srcaddr,
   output data_t resp_data,
   input  logic  resp_ready
   );

   logic advance;                                      // From response stage

   dec_exe_if dec_exe ();
   exe_res_if exe_res ();

   // ##########################################################################
   // Decode, execute, response
   // ##########################################################################

   umi_req_decode umi_req_decode_i (
      .clk         (clk),
      .nreset      (nreset),
      .req_valid   (req_valid),
      .req_cmd     (req_cmd),
      .req_dstaddr (req_dstaddr),
      .req_srcaddr (req_srcaddr),
      .req_data    (req_data),
      .advance     (advance),
      .req_ready   (req_ready),
      .dec         (dec_exe.src)
   );

   mem_access_exec mem_access_exec_i (
      .clk     (clk),
      .nreset  (nreset),
      .advance (advance),
      .dec     (dec_exe.dst),
      .exe     (exe_res.src)
   );

   umi_resp_builder umi_resp_builder_i (
      .clk          (clk),
      .nreset       (nreset),
      .exe          (exe_res.dst),
      .resp_ready   (resp_ready),
      .advance      (advance),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data)
   );

endmodule

// File: hdl/umi_req_decode.sv
`timescale 1ns/1ps

module umi_req_decode
   import mem_agent_pkg::*;
   (
   input  logic  clk,
   input  logic  nreset,
   input  logic  req_valid,
   input  cmd_t  req_cmd,
   input  addr_t req_dstaddr,
   input  addr_t req_srcaddr,
   input  data_t req_data,
   input  logic  advance,                              // Whole pipeline moves
   output logic  req_ready,
   dec_exe_if.src dec
   );

   opcode_t cmd_opcode;
   size_t   cmd_size;
   len_t    cmd_len;
   logic    op_known;

   logic    slot_valid;
   opcode_t slot_opcode;
   size_t   slot_size;
   len_t    slot_len;
   addr_t   slot_dstaddr;
   addr_t   slot_srcaddr;
   data_t   slot_wrdata;

   // ##########################################################################
   // Command split
   // ##########################################################################

   assign cmd_opcode = req_cmd[CMD_OPCODE_LSB +: $bits(opcode_t)];
   assign cmd_size   = req_cmd[CMD_SIZE_LSB +: $bits(size_t)];
   assign cmd_len    = req_cmd[CMD_LEN_LSB +: $bits(len_t)];

   // Anything else is silently dropped
   assign op_known = (cmd_opcode == REQ_RD) ||
                     (cmd_opcode == REQ_WR) ||
                     (cmd_opcode == REQ_WRPOSTED);

   assign req_ready = advance;                         // Combinational from resp_ready

   // Request slot
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         slot_valid <= 1'b0;
      else if (advance)
         slot_valid <= req_valid && op_known;          // Bubble when idle or unknown op
   end

   always_ff @(posedge clk) begin
      if (advance) begin                               // Payload, no reset
         slot_opcode  <= cmd_opcode;
         slot_size    <= cmd_size;
         slot_len     <= cmd_len;
         slot_dstaddr <= req_dstaddr;
         slot_srcaddr <= req_srcaddr;
         slot_wrdata  <= req_data;
      end
   end

   assign dec.valid   = slot_valid;
   assign dec.opcode  = slot_opcode;
   assign dec.size    = slot_size;
   assign dec.len     = slot_len;
   assign dec.dstaddr = slot_dstaddr;
   assign dec.srcaddr = slot_srcaddr;
   assign dec.wrdata  = slot_wrdata;

endmodule

// File: hdl/umi_resp_builder.sv
`timescale 1ns/1ps

module umi_resp_builder
   import mem_agent_pkg::*;
   (
   input  logic  clk,
   input  logic  nreset,
   exe_res_if.dst exe,
   input  logic  resp_ready,
   output logic  advance,                              // Shared slot load enable
   output logic  resp_valid,
   output cmd_t  resp_cmd,
   output addr_t resp_dstaddr,
   output addr_t resp_srcaddr,
   output data_t resp_data
   );

   logic    is_read;
   logic    needs_resp;
   opcode_t resp_opcode;
   cmd_t    cmd_next;

   // ##########################################################################
   // Response encoding
   // ##########################################################################

   assign is_read    = (exe.opcode == REQ_RD);
   assign needs_resp = exe.valid && (is_read || (exe.opcode == REQ_WR));   // Posted: none
   assign resp_opcode = is_read ? RESP_RD : RESP_WR;

   always_comb begin
      cmd_next = '0;                                   // Unused upper bits stay zero
      cmd_next[CMD_OPCODE_LSB +: $bits(opcode_t)] = resp_opcode;
      cmd_next[CMD_SIZE_LSB +: $bits(size_t)]     = exe.size;
      cmd_next[CMD_LEN_LSB +: $bits(len_t)]       = exe.len;
   end

   // Empty or draining this cycle
   assign advance = !resp_valid || resp_ready;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         resp_valid <= 1'b0;
      else if (advance)
         resp_valid <= needs_resp;
   end

   // Response register, only touched when a new packet lands
   always_ff @(posedge clk) begin
      if (advance && needs_resp) begin
         resp_cmd     <= cmd_next;
         resp_dstaddr <= exe.srcaddr;                  // Back to requester
         resp_srcaddr <= exe.dstaddr;
         resp_data    <= is_read ? exe.rddata : '0;    // Acks carry no data
      end
   end

endmodule
